//--- run.sh
#!/bin/sh
# build the core testbench with verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

build_dir=build
log=sim.log

if ! verilator --binary --timing --assert -f verilog.f --top-module core_tb \
    -Mdir "$build_dir" -o core_tb_sim; then
  echo "verilator build failed"
  exit 1
fi

if ! "./$build_dir/core_tb_sim" > "$log" 2>&1; then
  cat "$log"
  echo "simulation exited with an error status"
  exit 1
fi

cat "$log"

if grep -qx "test passed" "$log"; then
  exit 0
fi
exit 1

//--- testbench/core_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module core_tb;

  localparam int PROG_WORDS   = 32;
  localparam int FILE_WORDS   = 64;
  localparam int CYCLE_LIMIT  = 4 * PROG_WORDS + 50;
  localparam int DRAIN_CYCLES = 16;  // room for stray writes after the last pair

  logic                   clk = 1'b0;
  logic                   reset;
  logic [`XLEN-1:0]       imem_data;
  logic [`XLEN-1:0]       dmem_rdata;
  logic [`XLEN-1:0]       imem_addr;
  logic [`XLEN-1:0]       dmem_addr;
  logic [`XLEN-1:0]       dmem_wdata;
  logic                   dmem_we;
  logic                   dmem_re;
  logic                   wb_we;
  logic [`REG_ADDR_W-1:0] wb_rd;
  logic [`XLEN-1:0]       wb_data;

  logic [`XLEN-1:0] file_words [0:FILE_WORDS-1];
  logic [`XLEN-1:0] dmem [0:15];
  logic [3:0]       rd_index;  // word latched by the last read strobe
  logic [`XLEN-1:0] exp_rd [$];
  logic [`XLEN-1:0] exp_val [$];
  int               wb_seen;
  int               cycles;
  int               mismatches;
  int               extra_writes;
  int               missing_writes;

  pipe_core DUT (
    .clk_i       (clk),
    .reset_i     (reset),
    .imem_data_i (imem_data),
    .dmem_rdata_i(dmem_rdata),
    .imem_addr_o (imem_addr),
    .dmem_addr_o (dmem_addr),
    .dmem_wdata_o(dmem_wdata),
    .dmem_we_o   (dmem_we),
    .dmem_re_o   (dmem_re),
    .wb_we_o     (wb_we),
    .wb_rd_o     (wb_rd),
    .wb_data_o   (wb_data)
  );

  always #4 clk = ~clk;

  function automatic logic [`XLEN-1:0] rom_word(input logic [`XLEN-1:0] addr);
    if (addr[`XLEN-1:7] != '0) begin
      return `NOP_INSTR;  // past the program
    end
    return file_words[addr[6:2]];
  endfunction

  task automatic load_expected();
    int k;
    k = PROG_WORDS;
    while (k + 1 < FILE_WORDS && file_words[k] !== 32'hffff_ffff) begin
      exp_rd.push_back(file_words[k]);
      exp_val.push_back(file_words[k + 1]);
      k += 2;
    end
    if (exp_rd.size() == 0) begin
      $display("input file holds no expected write-backs");
      missing_writes++;
    end
  endtask

  task automatic compare_field(input string name, input logic [`XLEN-1:0] expected,
                               input logic [`XLEN-1:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] time %0d ns: %s expected %h got %h", $time, name, expected, actual);
      mismatches++;
    end
  endtask

  // memory models, inputs change on the falling edge
  always @(negedge clk) begin
    imem_data  <= rom_word(imem_addr);
    dmem_rdata <= dmem[rd_index];
  end

  always @(posedge clk) begin
    if (dmem_re) begin
      rd_index <= dmem_addr[5:2];
    end
    if (dmem_we) begin
      dmem[dmem_addr[5:2]] <= dmem_wdata;
    end
  end

  always @(posedge clk) begin
    if (!reset && wb_we) begin
      if (wb_seen >= exp_rd.size()) begin
        $display("unexpected write-back of %h to x%0d at %0d ns", wb_data, wb_rd, $time);
        extra_writes++;
      end else begin
        compare_field("wb_rd_o", exp_rd[wb_seen], `XLEN'(wb_rd));
        compare_field("wb_data_o", exp_val[wb_seen], wb_data);
      end
      wb_seen++;
    end
  end

  initial begin
    reset          = 1'b1;
    imem_data      = `NOP_INSTR;
    dmem_rdata     = '0;
    rd_index       = '0;
    wb_seen        = 0;
    cycles         = 0;
    mismatches     = 0;
    extra_writes   = 0;
    missing_writes = 0;
    for (int i = 0; i < FILE_WORDS; i++) begin
      file_words[i] = '0;
    end
    for (int i = 0; i < 16; i++) begin
      dmem[i] = 32'hd000_0000 | 32'(i * 4);  // byte address in the low bits
    end
    $readmemh("testbench/core_tb_input.hex", file_words);
    load_expected();

    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    while (wb_seen < exp_val.size() && cycles < CYCLE_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (wb_seen < exp_val.size()) begin
      missing_writes = missing_writes + exp_val.size() - wb_seen;
      $display("timeout after %0d cycles, %0d expected write-backs never arrived",
               cycles, exp_val.size() - wb_seen);
    end else begin
      repeat (DRAIN_CYCLES) @(negedge clk);
    end

    $display("errors: %0d mismatched, %0d extra, %0d missing write-backs",
             mismatches, extra_writes, missing_writes);
    if (mismatches + extra_writes + missing_writes == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/core_tb_input.hex
// words 0-31: program, two instruction words per line
// from word 32: expected write-backs as rd value pairs, ended by ffffffff
ffb00093 12345137  // addi x1,x0,-5   lui x2,0x12345
00001197 40110233  // auipc x3,1   sub x4,x2,x1
00402423 00802283  // sw x4,8(x0)   lw x5,8(x0)
0012c333 0020a3b3  // xor x6,x5,x1 after load-use stall   slt x7,x1,x2
0020b433 407354b3  // sltu x8,x1,x2   sra x9,x6,x7
00038663 00716533  // beq x7,x0 not taken   or x10,x2,x7
00a0c663 7ff00f93  // blt x1,x10 taken   slot marker
7fe00f93 009575b3  // skipped marker   and x11,x10,x9
00b0f663 7fd00f93  // bgeu x1,x11 taken   slot marker
7fc00f93 00b58663  // skipped marker   beq x11,x11 taken
7fb00f93 7fa00f93  // slot marker   skipped marker
00c0066f 7f900f93  // jal x12,+12   slot marker
7f600f93 014606e7  // skipped marker   jalr x13,20(x12)
7f800f93 7f700f93  // slot marker   skipped marker
12300013 00d00733  // addi x0,x0,0x123   add x14,x0,x13
00000013 00000013  // padding
00000001 fffffffb
00000002 12345000
00000003 00001008
00000004 12345005
00000005 12345005  // loaded back
00000006 edcbaffe
00000007 00000001
00000008 00000000
00000009 f6e5d7ff
0000000a 12345001
0000000b 12245001
0000000c 0000005c  // jal link
0000000d 00000068  // jalr link
0000000e 00000068
ffffffff

//--- verilog.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/regfile.sv
verilog/id.sv
verilog/alu.sv
verilog/pipe_core.sv
testbench/core_tb.sv

//--- verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module alu (
  input  var cpu_pkg::id_ex_t ex_i,
  output logic [`XLEN-1:0]    result_o
);

  logic [`XLEN-1:0] op1;
  logic [`XLEN-1:0] op2;
  logic [4:0]       shamt;

  assign op1 = (ex_i.alusrc1 == cpu_pkg::SRC1_FROM_PC) ? ex_i.pc : ex_i.rs1_data;
  assign op2 = (ex_i.alusrc2 == cpu_pkg::SRC2_FROM_IMM) ? ex_i.imm : ex_i.rs2_data;

  assign shamt = op2[4:0];  // upper bits ignored

  always_comb begin
    case (ex_i.aluop)
      cpu_pkg::ALUOP_ADD: begin
        result_o = op1 + op2;
      end
      cpu_pkg::ALUOP_SUB: begin
        result_o = op1 - op2;
      end
      cpu_pkg::ALUOP_SLL: begin
        result_o = op1 << shamt;
      end
      cpu_pkg::ALUOP_SLT: begin
        result_o = `XLEN'($signed(op1) < $signed(op2));
      end
      cpu_pkg::ALUOP_SLTU: begin
        result_o = `XLEN'(op1 < op2);
      end
      cpu_pkg::ALUOP_XOR: begin
        result_o = op1 ^ op2;
      end
      cpu_pkg::ALUOP_SRL: begin
        result_o = op1 >> shamt;
      end
      cpu_pkg::ALUOP_SRA: begin
        result_o = $unsigned($signed(op1) >>> shamt);
      end
      cpu_pkg::ALUOP_OR: begin
        result_o = op1 | op2;
      end
      cpu_pkg::ALUOP_AND: begin
        result_o = op1 & op2;
      end
      cpu_pkg::ALUOP_LINK: begin
        result_o = ex_i.link_addr;  // jal/jalr return address
      end
      default: begin
        result_o = op1 + op2;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/cpu_pkg.sv
`default_nettype none
`include "cpu_settings.svh"

package cpu_pkg;

  // major opcodes, rv32i
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_ARITHI = 7'b0010011,
    OP_ARITHR = 7'b0110011,
    OP_FENCE  = 7'b0001111,
    OP_SYSTEM = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    ALUOP_ADD,
    ALUOP_SUB,
    ALUOP_SLL,
    ALUOP_SLT,
    ALUOP_SLTU,
    ALUOP_XOR,
    ALUOP_SRL,
    ALUOP_SRA,
    ALUOP_OR,
    ALUOP_AND,
    ALUOP_LINK  // passes link address through
  } aluop_t;

  typedef enum logic {SRC1_FROM_REG = 1'b0, SRC1_FROM_PC  = 1'b1} alusrc1_t;
  typedef enum logic {SRC2_FROM_REG = 1'b0, SRC2_FROM_IMM = 1'b1} alusrc2_t;

  typedef struct packed {
    logic [`XLEN-1:0]       pc;
    aluop_t                 aluop;
    alusrc1_t               alusrc1;
    alusrc2_t               alusrc2;
    logic [`XLEN-1:0]       imm;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;  // also store data
    logic [`REG_ADDR_W-1:0] rd;
    logic                   wreg;
    logic                   memrd;
    logic                   memwr;
    logic                   mem2reg;
    logic [`XLEN-1:0]       link_addr;
  } id_ex_t;

  typedef struct packed {
    logic [`XLEN-1:0]       result;  // doubles as memory address
    logic [`XLEN-1:0]       store_data;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   wreg;
    logic                   memrd;
    logic                   memwr;
    logic                   mem2reg;
  } ex_mem_t;

  typedef struct packed {
    logic [`XLEN-1:0]       result;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   wreg;
    logic                   mem2reg;
  } mem_wb_t;

endpackage

`default_nettype wire

//--- verilog/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath widths
`define XLEN        32
`define REG_ADDR_W  5

`define RESET_PC    32'h0000_0000

// instruction field ranges
`define OPCODE_R    6:0
`define RD_R        11:7
`define FUNC3_R     14:12
`define RS1_R       19:15
`define RS2_R       24:20
`define FUNC7_R     31:25

`define NOP_INSTR   32'h0000_0013  // addi x0, x0, 0

`endif

//--- verilog/id.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module id (
  input  wire  [`XLEN-1:0]       pc_i,
  input  wire  [`XLEN-1:0]       inst_i,
  input  wire  [`XLEN-1:0]       rs1_data_i,
  input  wire  [`XLEN-1:0]       rs2_data_i,
  input  wire                    ex_wreg_i,
  input  wire  [`XLEN-1:0]       ex_wreg_data_i,
  input  wire  [`REG_ADDR_W-1:0] ex_rd_i,
  input  wire                    ex_memrd_i,
  input  wire                    mem_wreg_i,
  input  wire  [`XLEN-1:0]       mem_wreg_data_i,
  input  wire  [`REG_ADDR_W-1:0] mem_rd_i,
  input  wire                    mem_memrd_i,
  input  wire                    is_in_delayslot_i,
  output logic                   rs1_read_o,
  output logic                   rs2_read_o,
  output logic [`REG_ADDR_W-1:0] rs1_addr_o,
  output logic [`REG_ADDR_W-1:0] rs2_addr_o,
  output cpu_pkg::id_ex_t        dec_o,
  output logic                   branch_taken_o,
  output logic [`XLEN-1:0]       branch_target_addr_o,
  output logic                   next_inst_in_delayslot_o,
  output logic                   stallreq_o
);

  cpu_pkg::opcode_t opcode;
  logic [2:0]       func3;
  logic [6:0]       func7;
  logic [`XLEN-1:0] pc_plus4;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_j;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] rs1_val;
  logic [`XLEN-1:0] rs2_val;
  logic             cond;

  assign opcode   = cpu_pkg::opcode_t'(inst_i[`OPCODE_R]);
  assign func3    = inst_i[`FUNC3_R];
  assign func7    = inst_i[`FUNC7_R];
  assign pc_plus4 = pc_i + `XLEN'(4);

  assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
  assign imm_u = {inst_i[31:12], 12'b0};

  // source usage per opcode, nothing read from a squashed slot
  always_comb begin
    rs1_read_o = 1'b0;
    rs2_read_o = 1'b0;
    if (!is_in_delayslot_i) begin
      case (opcode)
        cpu_pkg::OP_JALR, cpu_pkg::OP_LOAD, cpu_pkg::OP_ARITHI: begin
          rs1_read_o = 1'b1;
        end
        cpu_pkg::OP_BRANCH, cpu_pkg::OP_STORE, cpu_pkg::OP_ARITHR: begin
          rs1_read_o = 1'b1;
          rs2_read_o = 1'b1;
        end
        default: ;
      endcase
    end
    rs1_addr_o = rs1_read_o ? inst_i[`RS1_R] : '0;
    rs2_addr_o = rs2_read_o ? inst_i[`RS2_R] : '0;
  end

  // ex beats mem beats regfile
  function automatic logic [`XLEN-1:0] fwd(input logic rd_en,
                                           input logic [`REG_ADDR_W-1:0] addr,
                                           input logic [`XLEN-1:0] rf_data);
    logic [`XLEN-1:0] val;
    if (!rd_en || addr == '0) begin
      val = '0;
    end else if (ex_wreg_i && ex_rd_i == addr) begin
      val = ex_wreg_data_i;
    end else if (mem_wreg_i && mem_rd_i == addr) begin
      val = mem_wreg_data_i;
    end else begin
      val = rf_data;
    end
    return val;
  endfunction

  function automatic logic load_use(input logic rd_en,
                                    input logic [`REG_ADDR_W-1:0] addr);
    logic hit_ex;
    logic hit_mem;
    hit_ex  = ex_memrd_i && ex_wreg_i && ex_rd_i == addr;
    hit_mem = mem_memrd_i && mem_wreg_i && mem_rd_i == addr;
    return rd_en && addr != '0 && (hit_ex || hit_mem);
  endfunction

  always_comb begin
    rs1_val    = fwd(rs1_read_o, rs1_addr_o, rs1_data_i);
    rs2_val    = fwd(rs2_read_o, rs2_addr_o, rs2_data_i);
    stallreq_o = load_use(rs1_read_o, rs1_addr_o) || load_use(rs2_read_o, rs2_addr_o);
  end

  always_comb begin
    case (func3)
      3'b000:  cond = (rs1_val == rs2_val);                  // beq
      3'b001:  cond = (rs1_val != rs2_val);                  // bne
      3'b100:  cond = ($signed(rs1_val) < $signed(rs2_val));  // blt
      3'b101:  cond = ($signed(rs1_val) >= $signed(rs2_val)); // bge
      3'b110:  cond = (rs1_val < rs2_val);                   // bltu
      3'b111:  cond = (rs1_val >= rs2_val);                  // bgeu
      default: cond = 1'b0;
    endcase
  end

  always_comb begin
    dec_o                = '0;
    dec_o.pc             = pc_i;
    dec_o.aluop          = cpu_pkg::ALUOP_ADD;
    dec_o.alusrc1        = cpu_pkg::SRC1_FROM_REG;
    dec_o.alusrc2        = cpu_pkg::SRC2_FROM_REG;
    dec_o.rs1_data       = rs1_val;
    dec_o.rs2_data       = rs2_val;
    dec_o.link_addr      = pc_plus4;
    branch_taken_o       = 1'b0;
    branch_target_addr_o = pc_i + imm_b;
    if (!is_in_delayslot_i) begin
      case (opcode)
        cpu_pkg::OP_LUI, cpu_pkg::OP_AUIPC: begin
          dec_o.rd      = inst_i[`RD_R];
          dec_o.wreg    = 1'b1;
          dec_o.imm     = imm_u;
          dec_o.alusrc2 = cpu_pkg::SRC2_FROM_IMM;
          if (opcode == cpu_pkg::OP_AUIPC) begin
            dec_o.alusrc1 = cpu_pkg::SRC1_FROM_PC;
          end
        end
        cpu_pkg::OP_JAL: begin
          dec_o.aluop          = cpu_pkg::ALUOP_LINK;
          dec_o.rd             = inst_i[`RD_R];
          dec_o.wreg           = 1'b1;
          dec_o.imm            = imm_j;
          branch_target_addr_o = pc_i + imm_j;
          branch_taken_o       = 1'b1;
        end
        cpu_pkg::OP_JALR: begin
          dec_o.aluop          = cpu_pkg::ALUOP_LINK;
          dec_o.rd             = inst_i[`RD_R];
          dec_o.wreg           = 1'b1;
          dec_o.imm            = imm_i;
          branch_target_addr_o = (rs1_val + imm_i) & ~`XLEN'(1);
          branch_taken_o       = 1'b1;
        end
        cpu_pkg::OP_BRANCH: begin
          dec_o.imm      = imm_b;
          branch_taken_o = cond;
        end
        cpu_pkg::OP_LOAD: begin
          dec_o.rd      = inst_i[`RD_R];
          dec_o.wreg    = 1'b1;
          dec_o.memrd   = 1'b1;
          dec_o.mem2reg = 1'b1;
          dec_o.imm     = imm_i;
          dec_o.alusrc2 = cpu_pkg::SRC2_FROM_IMM;
        end
        cpu_pkg::OP_STORE: begin
          dec_o.memwr   = 1'b1;
          dec_o.imm     = imm_s;
          dec_o.alusrc2 = cpu_pkg::SRC2_FROM_IMM;
        end
        cpu_pkg::OP_ARITHI, cpu_pkg::OP_ARITHR: begin
          dec_o.rd   = inst_i[`RD_R];
          dec_o.wreg = 1'b1;
          if (opcode == cpu_pkg::OP_ARITHI) begin
            dec_o.imm     = imm_i;
            dec_o.alusrc2 = cpu_pkg::SRC2_FROM_IMM;
          end
          case (func3)
            3'b000: begin
              // sub only exists in the register form
              if (opcode == cpu_pkg::OP_ARITHR && func7[5]) begin
                dec_o.aluop = cpu_pkg::ALUOP_SUB;
              end
            end
            3'b001:  dec_o.aluop = cpu_pkg::ALUOP_SLL;
            3'b010:  dec_o.aluop = cpu_pkg::ALUOP_SLT;
            3'b011:  dec_o.aluop = cpu_pkg::ALUOP_SLTU;
            3'b100:  dec_o.aluop = cpu_pkg::ALUOP_XOR;
            3'b101:  dec_o.aluop = func7[5] ? cpu_pkg::ALUOP_SRA : cpu_pkg::ALUOP_SRL;
            3'b110:  dec_o.aluop = cpu_pkg::ALUOP_OR;
            default: dec_o.aluop = cpu_pkg::ALUOP_AND;
          endcase
        end
        default: ;  // fence, system
      endcase
    end
    next_inst_in_delayslot_o = branch_taken_o;
  end

  // a slot trails its branch in execute, never a load
  always_comb begin
    a_slot_after_branch: assert (!(is_in_delayslot_i && ex_memrd_i));
  end

endmodule

`default_nettype wire

//--- verilog/pipe_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module pipe_core (
  input  wire                    clk_i,
  input  wire                    reset_i,
  input  wire  [`XLEN-1:0]       imem_data_i,
  input  wire  [`XLEN-1:0]       dmem_rdata_i,
  output logic [`XLEN-1:0]       imem_addr_o,
  output logic [`XLEN-1:0]       dmem_addr_o,
  output logic [`XLEN-1:0]       dmem_wdata_o,
  output logic                   dmem_we_o,
  output logic                   dmem_re_o,
  output logic                   wb_we_o,
  output logic [`REG_ADDR_W-1:0] wb_rd_o,
  output logic [`XLEN-1:0]       wb_data_o
);

  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] if_id_pc;
  logic [`XLEN-1:0] if_id_inst;
  logic             if_id_slot;  // fetched in a branch delay slot

  cpu_pkg::id_ex_t  dec;
  cpu_pkg::id_ex_t  id_ex;
  cpu_pkg::ex_mem_t ex_mem;
  cpu_pkg::mem_wb_t mem_wb;

  logic                   rs1_read;
  logic                   rs2_read;
  logic [`REG_ADDR_W-1:0] rs1_addr;
  logic [`REG_ADDR_W-1:0] rs2_addr;
  logic [`XLEN-1:0]       rs1_data;
  logic [`XLEN-1:0]       rs2_data;
  logic [`XLEN-1:0]       alu_result;
  logic                   branch_taken;
  logic [`XLEN-1:0]       branch_target;
  logic                   next_slot;
  logic                   stall;

  assign imem_addr_o = pc;

  // redirect only counts once decode is not repeating
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc <= `RESET_PC;
    end else if (!stall) begin
      pc <= branch_taken ? branch_target : pc + `XLEN'(4);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      if_id_pc   <= `RESET_PC;
      if_id_inst <= `NOP_INSTR;
      if_id_slot <= 1'b0;
    end else if (!stall) begin
      if_id_pc   <= pc;
      if_id_inst <= imem_data_i;
      if_id_slot <= next_slot;
    end
  end

  regfile u_regfile (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .re1_i   (rs1_read),
    .re2_i   (rs2_read),
    .raddr1_i(rs1_addr),
    .raddr2_i(rs2_addr),
    .we_i    (wb_we_o),
    .waddr_i (wb_rd_o),
    .wdata_i (wb_data_o),
    .rdata1_o(rs1_data),
    .rdata2_o(rs2_data)
  );

  id u_id (
    .pc_i                    (if_id_pc),
    .inst_i                  (if_id_inst),
    .rs1_data_i              (rs1_data),
    .rs2_data_i              (rs2_data),
    .ex_wreg_i               (id_ex.wreg),
    .ex_wreg_data_i          (alu_result),
    .ex_rd_i                 (id_ex.rd),
    .ex_memrd_i              (id_ex.memrd),
    .mem_wreg_i              (ex_mem.wreg),
    .mem_wreg_data_i         (ex_mem.result),
    .mem_rd_i                (ex_mem.rd),
    .mem_memrd_i             (ex_mem.memrd),
    .is_in_delayslot_i       (if_id_slot),
    .rs1_read_o              (rs1_read),
    .rs2_read_o              (rs2_read),
    .rs1_addr_o              (rs1_addr),
    .rs2_addr_o              (rs2_addr),
    .dec_o                   (dec),
    .branch_taken_o          (branch_taken),
    .branch_target_addr_o    (branch_target),
    .next_inst_in_delayslot_o(next_slot),
    .stallreq_o              (stall)
  );

  always_ff @(posedge clk_i) begin
    if (reset_i || stall) begin
      id_ex <= '0;  // bubble
    end else begin
      id_ex <= dec;
    end
  end

  alu u_alu (
    .ex_i    (id_ex),
    .result_o(alu_result)
  );

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ex_mem <= '0;
    end else begin
      ex_mem.result     <= alu_result;
      ex_mem.store_data <= id_ex.rs2_data;
      ex_mem.rd         <= id_ex.rd;
      ex_mem.wreg       <= id_ex.wreg;
      ex_mem.memrd      <= id_ex.memrd;
      ex_mem.memwr      <= id_ex.memwr;
      ex_mem.mem2reg    <= id_ex.mem2reg;
    end
  end

  // word access only, read data lands in write-back
  assign dmem_addr_o  = ex_mem.result;
  assign dmem_wdata_o = ex_mem.store_data;
  assign dmem_we_o    = ex_mem.memwr;
  assign dmem_re_o    = ex_mem.memrd;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mem_wb <= '0;
    end else begin
      mem_wb.result  <= ex_mem.result;
      mem_wb.rd      <= ex_mem.rd;
      mem_wb.wreg    <= ex_mem.wreg;
      mem_wb.mem2reg <= ex_mem.mem2reg;
    end
  end

  assign wb_we_o   = mem_wb.wreg && (mem_wb.rd != '0);
  assign wb_rd_o   = mem_wb.rd;
  assign wb_data_o = mem_wb.mem2reg ? dmem_rdata_i : mem_wb.result;

endmodule

`default_nettype wire

//--- verilog/regfile.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module regfile (
  input  wire                    clk_i,
  input  wire                    reset_i,
  input  wire                    re1_i,
  input  wire                    re2_i,
  input  wire  [`REG_ADDR_W-1:0] raddr1_i,
  input  wire  [`REG_ADDR_W-1:0] raddr2_i,
  input  wire                    we_i,
  input  wire  [`REG_ADDR_W-1:0] waddr_i,
  input  wire  [`XLEN-1:0]       wdata_i,
  output logic [`XLEN-1:0]       rdata1_o,
  output logic [`XLEN-1:0]       rdata2_o
);

  logic [`XLEN-1:0] regs [1:31];  // x0 has no storage
  logic             wr_live;

  assign wr_live = we_i && (waddr_i != '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  function automatic logic [`XLEN-1:0] read_port(input logic re,
                                                 input logic [`REG_ADDR_W-1:0] addr);
    logic [`XLEN-1:0] data;
    if (!re || addr == '0) begin
      data = '0;
    end else if (wr_live && waddr_i == addr) begin
      data = wdata_i;  // write-first bypass
    end else begin
      data = regs[addr];
    end
    return data;
  endfunction

  always_comb begin
    rdata1_o = read_port(re1_i, raddr1_i);
    rdata2_o = read_port(re2_i, raddr2_i);
  end

  // stored value reads back next cycle unless rewritten
  a_readback1: assert property (@(posedge clk_i) disable iff (reset_i)
    wr_live |=> (!re1_i || raddr1_i != $past(waddr_i) || (wr_live && waddr_i == raddr1_i)
                 || rdata1_o == $past(wdata_i)));

  a_readback2: assert property (@(posedge clk_i) disable iff (reset_i)
    wr_live |=> (!re2_i || raddr2_i != $past(waddr_i) || (wr_live && waddr_i == raddr2_i)
                 || rdata2_o == $past(wdata_i)));

endmodule

`default_nettype wire
